// ==== source/tlb_macros.svh ====
/*
 * TLB constants
 * Entry count, field widths of the page-pair entries and the
 * cache attribute code that marks a page as cacheable.
 */
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// Table size
`define TLB_ENTRIES   16
`define TLB_IDX_W     4

// Address split, 4 KB pages in even/odd pairs
`define ADDR_W        32
`define PAGE_OFS_W    12
`define VPN2_W        19
`define PFN_W         20
`define ASID_W        8

// Cache attribute
`define CATTR_W       3
`define CATTR_CACHED  3

`endif

// ==== source/tlb_pkg.sv ====
/*
 * TLB types
 * CP0 operation codes and the key, page and entry structures
 * shared by the table, the match logic and the controller.
 */
`default_nettype none

`include "tlb_macros.svh"

package tlb_pkg;

    // Encoding needs 3 bits for five operations
    typedef enum logic [2:0] {
        op_nop        = 3'd0,
        op_read       = 3'd1,
        op_write_idx  = 3'd2,
        op_write_rand = 3'd3,
        op_probe      = 3'd4
    } tlb_op_e;

    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;

    typedef struct packed {
        logic [`VPN2_W-1:0] vpn2;
        logic [`ASID_W-1:0] asid;
    } entry_hi_t;

    typedef struct packed {
        logic [`PFN_W-1:0]   pfn;
        logic [`CATTR_W-1:0] cattr;
        logic                dirty;
        logic                valid;
        logic                glb;
    } entry_lo_t;

    // One page half as stored, no global bit
    typedef struct packed {
        logic [`PFN_W-1:0]   pfn;
        logic [`CATTR_W-1:0] cattr;
        logic                dirty;
        logic                valid;
    } tlb_page_t;

    typedef struct packed {
        entry_hi_t key;
        logic      glb;
        tlb_page_t lo0;
        tlb_page_t lo1;
    } tlb_entry_t;

    typedef struct packed {
        logic     miss;
        tlb_idx_t idx;
    } probe_t;

endpackage

`default_nettype wire

// ==== source/tlb_entry_array.sv ====
/*
 * TLB entry storage
 * Holds the page-pair entries, clears them on reset, writes one
 * entry per enabled clock edge and reads one entry without delay.
 * The whole table is exposed for the parallel match logic.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_entry_array
    import tlb_pkg::*;
(
    input  wire        clk,
    input  wire        rst,

    input  wire        i_wen,
    input  tlb_idx_t   i_widx,
    input  tlb_entry_t i_wentry,

    input  tlb_idx_t   i_ridx,
    output tlb_entry_t o_rentry,

    output tlb_entry_t o_entries [`TLB_ENTRIES]
);

    tlb_entry_t entries [`TLB_ENTRIES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (i_wen) begin
            entries[i_widx] <= i_wentry;
        end
    end

    assign o_rentry  = entries[i_ridx]; // Combinational read
    assign o_entries = entries;

    // Controller must hold writes off while the table is being cleared
    a_no_write_in_reset: assert property (
        @(posedge clk) rst |-> !i_wen
    ) else $error("TLB write during reset");

endmodule

`default_nettype wire

// ==== source/tlb_match.sv ====
/*
 * TLB match
 * Compares one key against every entry in parallel. An entry hits
 * when its vpn2 matches and it is global or its asid matches.
 * Among several hits the highest index wins.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_match
    import tlb_pkg::*;
(
    input  tlb_entry_t i_entries [`TLB_ENTRIES],
    input  entry_hi_t  i_key,
    output logic       o_hit,
    output tlb_idx_t   o_hit_idx
);

    logic [`TLB_ENTRIES-1:0] hit_vec;

    genvar g;
    generate
        for (g = 0; g < `TLB_ENTRIES; g++) begin : g_cmp
            logic vpn_eq;
            logic asid_ok;

            assign vpn_eq  = i_entries[g].key.vpn2 == i_key.vpn2;
            assign asid_ok = i_entries[g].glb ||
                             (i_entries[g].key.asid == i_key.asid);
            assign hit_vec[g] = vpn_eq && asid_ok;
        end
    endgenerate

    // Later hits overwrite earlier ones
    always_comb begin
        o_hit     = |hit_vec;
        o_hit_idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                o_hit_idx = tlb_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tlb_translate_ctrl.sv ====
/*
 * TLB controller
 * Data-side translation sequence (idle, translate, ready) with a
 * one-entry lookaside of the last result, page-half select and the
 * refill, invalid and modified flags. Also decodes the CP0 table
 * operations into writes and one-cycle read and probe strobes.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_translate_ctrl
    import tlb_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,

    input  tlb_op_e                 i_tlb_op,
    input  tlb_idx_t                i_index,
    input  tlb_idx_t                i_random,
    input  entry_hi_t               i_entry_hi,
    input  entry_lo_t               i_entry_lo0,
    input  entry_lo_t               i_entry_lo1,

    input  wire                     i_dmmu_en,
    input  wire [`ADDR_W-1:0]       i_dmmu_vaddr,
    input  wire                     i_dmmu_store,

    input  wire                     i_xl_hit,
    input  tlb_idx_t                i_xl_idx,
    input  wire                     i_pr_hit,
    input  tlb_idx_t                i_pr_idx,
    input  tlb_entry_t              i_rentry,

    output logic                    o_wen,
    output tlb_idx_t                o_widx,
    output tlb_entry_t              o_wentry,
    output tlb_idx_t                o_ridx,
    output entry_hi_t               o_xl_key,

    output logic                    o_dmmu_rdy,
    output logic [`ADDR_W-1:0]      o_dmmu_paddr,
    output logic                    o_dmmu_cached,
    output logic                    o_tlb_refill,
    output logic                    o_tlb_invalid,
    output logic                    o_tlb_modified,

    output logic                    o_probe_wen,
    output probe_t                  o_probe_result,
    output logic                    o_read_wen,
    output tlb_entry_t              o_read_entry
);

    typedef enum logic [1:0] {st_idle, st_translate, st_ready} xl_state_e;

    xl_state_e          state;
    logic [`ADDR_W-1:0] vaddr_q;
    logic [`ASID_W-1:0] asid_q;
    logic               lk_valid;
    logic               miss_q;
    tlb_idx_t           idx_q;
    tlb_page_t          page_sel;
    logic               start;

    assign o_dmmu_rdy = i_dmmu_en && (i_dmmu_vaddr == vaddr_q) && lk_valid &&
                        (i_entry_hi.asid == asid_q);
    assign start = (state == st_idle) && i_dmmu_en && !o_dmmu_rdy && (i_tlb_op == op_nop);

    assign o_xl_key = '{vpn2: vaddr_q[`ADDR_W-1 -: `VPN2_W], asid: asid_q};

    // CP0 read has the port, translation waits a cycle on collision
    assign o_ridx   = (i_tlb_op == op_read) ? i_index : idx_q;
    assign page_sel = vaddr_q[`PAGE_OFS_W] ? i_rentry.lo1 : i_rentry.lo0; // Odd/even page

    assign o_wen  = (i_tlb_op == op_write_idx) || (i_tlb_op == op_write_rand);
    assign o_widx = (i_tlb_op == op_write_rand) ? i_random : i_index;

    always_comb begin
        o_wentry           = '0;
        o_wentry.key       = i_entry_hi;
        o_wentry.glb       = i_entry_lo0.glb & i_entry_lo1.glb;
        o_wentry.lo0.pfn   = i_entry_lo0.pfn;
        o_wentry.lo0.cattr = i_entry_lo0.cattr;
        o_wentry.lo0.dirty = i_entry_lo0.dirty;
        o_wentry.lo0.valid = i_entry_lo0.valid;
        o_wentry.lo1.pfn   = i_entry_lo1.pfn;
        o_wentry.lo1.cattr = i_entry_lo1.cattr;
        o_wentry.lo1.dirty = i_entry_lo1.dirty;
        o_wentry.lo1.valid = i_entry_lo1.valid;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= st_idle;
            vaddr_q        <= '0;
            asid_q         <= '0;
            lk_valid       <= 1'b0;
            miss_q         <= 1'b0;
            idx_q          <= '0;
            o_dmmu_paddr   <= '0;
            o_dmmu_cached  <= 1'b0;
            o_tlb_refill   <= 1'b0;
            o_tlb_invalid  <= 1'b0;
            o_tlb_modified <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state          <= st_translate;
                        vaddr_q        <= i_dmmu_vaddr;
                        asid_q         <= i_entry_hi.asid;
                        lk_valid       <= 1'b0;
                        o_tlb_refill   <= 1'b0;
                        o_tlb_invalid  <= 1'b0;
                        o_tlb_modified <= 1'b0;
                    end
                end
                st_translate: begin
                    miss_q <= !i_xl_hit;
                    idx_q  <= i_xl_idx; // Entry read in next state
                    state  <= st_ready;
                end
                default: begin
                    if (i_tlb_op != op_read) begin
                        o_tlb_refill <= miss_q;
                        if (miss_q) begin
                            o_dmmu_paddr   <= '0;
                            o_dmmu_cached  <= 1'b0;
                            o_tlb_invalid  <= 1'b0;
                            o_tlb_modified <= 1'b0;
                        end else begin
                            o_dmmu_paddr   <= {page_sel.pfn, vaddr_q[`PAGE_OFS_W-1:0]};
                            o_dmmu_cached  <= page_sel.cattr == `CATTR_W'(`CATTR_CACHED);
                            o_tlb_invalid  <= !page_sel.valid;
                            o_tlb_modified <= page_sel.valid && !page_sel.dirty &&
                                              i_dmmu_store;
                        end
                        lk_valid <= 1'b1;
                        state    <= st_idle;
                    end
                end
            endcase
        end
    end

    // CP0 strobes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_read_wen  <= 1'b0;
            o_probe_wen <= 1'b0;
        end else begin
            o_read_wen  <= i_tlb_op == op_read;
            o_probe_wen <= i_tlb_op == op_probe;
        end
    end

    always_ff @(posedge clk) begin
        if (i_tlb_op == op_read) begin
            o_read_entry <= i_rentry;
        end
        if (i_tlb_op == op_probe) begin
            o_probe_result.miss <= !i_pr_hit;
            o_probe_result.idx  <= i_pr_hit ? i_pr_idx : '0; // Index 0 on miss
        end
    end

    // CPU holds its request until the result is ready
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (state != st_idle) |-> i_dmmu_en && $stable(i_dmmu_vaddr) && $stable(i_dmmu_store)
    ) else $error("Translation request changed before ready");

endmodule

`default_nettype wire

// ==== source/tlb_unit.sv ====
/*
 * TLB top level
 * Connects the entry table, the translation and probe match
 * instances and the controller.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_unit
    import tlb_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,

    input  tlb_op_e             i_tlb_op,
    input  tlb_idx_t            i_index,
    input  tlb_idx_t            i_random,
    input  entry_hi_t           i_entry_hi,
    input  entry_lo_t           i_entry_lo0,
    input  entry_lo_t           i_entry_lo1,

    input  wire                 i_dmmu_en,
    input  wire [`ADDR_W-1:0]   i_dmmu_vaddr,
    input  wire                 i_dmmu_store,
    output logic                o_dmmu_rdy,
    output logic [`ADDR_W-1:0]  o_dmmu_paddr,
    output logic                o_dmmu_cached,
    output logic                o_tlb_refill,
    output logic                o_tlb_invalid,
    output logic                o_tlb_modified,

    output logic                o_probe_wen,
    output probe_t              o_probe_result,
    output logic                o_read_wen,
    output tlb_entry_t          o_read_entry
);

    tlb_entry_t entries [`TLB_ENTRIES];
    tlb_entry_t rentry;
    tlb_entry_t wentry;
    tlb_idx_t   widx;
    tlb_idx_t   ridx;
    tlb_idx_t   xl_idx;
    tlb_idx_t   pr_idx;
    entry_hi_t  xl_key;
    logic       wen;
    logic       xl_hit;
    logic       pr_hit;

    tlb_entry_array u_array (
        .clk       (clk),
        .rst       (rst),
        .i_wen     (wen),
        .i_widx    (widx),
        .i_wentry  (wentry),
        .i_ridx    (ridx),
        .o_rentry  (rentry),
        .o_entries (entries)
    );

    tlb_match u_xlate (
        .i_entries (entries),
        .i_key     (xl_key),
        .o_hit     (xl_hit),
        .o_hit_idx (xl_idx)
    );

    tlb_match u_probe (
        .i_entries (entries),
        .i_key     (i_entry_hi),
        .o_hit     (pr_hit),
        .o_hit_idx (pr_idx)
    );

    tlb_translate_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .i_tlb_op       (i_tlb_op),
        .i_index        (i_index),
        .i_random       (i_random),
        .i_entry_hi     (i_entry_hi),
        .i_entry_lo0    (i_entry_lo0),
        .i_entry_lo1    (i_entry_lo1),
        .i_dmmu_en      (i_dmmu_en),
        .i_dmmu_vaddr   (i_dmmu_vaddr),
        .i_dmmu_store   (i_dmmu_store),
        .i_xl_hit       (xl_hit),
        .i_xl_idx       (xl_idx),
        .i_pr_hit       (pr_hit),
        .i_pr_idx       (pr_idx),
        .i_rentry       (rentry),
        .o_wen          (wen),
        .o_widx         (widx),
        .o_wentry       (wentry),
        .o_ridx         (ridx),
        .o_xl_key       (xl_key),
        .o_dmmu_rdy     (o_dmmu_rdy),
        .o_dmmu_paddr   (o_dmmu_paddr),
        .o_dmmu_cached  (o_dmmu_cached),
        .o_tlb_refill   (o_tlb_refill),
        .o_tlb_invalid  (o_tlb_invalid),
        .o_tlb_modified (o_tlb_modified),
        .o_probe_wen    (o_probe_wen),
        .o_probe_result (o_probe_result),
        .o_read_wen     (o_read_wen),
        .o_read_entry   (o_read_entry)
    );

endmodule

`default_nettype wire

// ==== verification/tlb_unit_tb.sv ====
/*
 * TLB testbench
 * Random CP0 writes, reads and probes plus data-side translations,
 * checked against a reference table kept in the testbench. Also
 * covers the one-entry lookaside and the fixed translation latency.
 */
`timescale 1ns/1ps
`default_nettype none

`include "tlb_macros.svh"

module tlb_unit_tb
    import tlb_pkg::*;
;

    localparam int WAIT_LIMIT = 20;
    localparam int NUM_OPS    = 400;

    logic                clk;
    logic                rst;
    tlb_op_e             i_tlb_op;
    tlb_idx_t            i_index;
    tlb_idx_t            i_random;
    entry_hi_t           i_entry_hi;
    entry_lo_t           i_entry_lo0;
    entry_lo_t           i_entry_lo1;
    logic                i_dmmu_en;
    logic [`ADDR_W-1:0]  i_dmmu_vaddr;
    logic                i_dmmu_store;
    logic                o_dmmu_rdy;
    logic [`ADDR_W-1:0]  o_dmmu_paddr;
    logic                o_dmmu_cached;
    logic                o_tlb_refill;
    logic                o_tlb_invalid;
    logic                o_tlb_modified;
    logic                o_probe_wen;
    probe_t              o_probe_result;
    logic                o_read_wen;
    tlb_entry_t          o_read_entry;

    integer              seed;
    tlb_entry_t          model [`TLB_ENTRIES];
    logic [`VPN2_W-1:0]  vpn2_pool [8];
    logic [`ASID_W-1:0]  asid_pool [4];

    // Last translation result as the DUT should hold it
    logic                lk_valid;
    logic [`ADDR_W-1:0]  lk_vaddr;
    logic [`ASID_W-1:0]  lk_asid;
    logic [`ADDR_W-1:0]  lk_paddr;
    logic                lk_cached;
    logic                lk_refill;
    logic                lk_invalid;
    logic                lk_modified;

    tlb_unit dut (
        .clk            (clk),
        .rst            (rst),
        .i_tlb_op       (i_tlb_op),
        .i_index        (i_index),
        .i_random       (i_random),
        .i_entry_hi     (i_entry_hi),
        .i_entry_lo0    (i_entry_lo0),
        .i_entry_lo1    (i_entry_lo1),
        .i_dmmu_en      (i_dmmu_en),
        .i_dmmu_vaddr   (i_dmmu_vaddr),
        .i_dmmu_store   (i_dmmu_store),
        .o_dmmu_rdy     (o_dmmu_rdy),
        .o_dmmu_paddr   (o_dmmu_paddr),
        .o_dmmu_cached  (o_dmmu_cached),
        .o_tlb_refill   (o_tlb_refill),
        .o_tlb_invalid  (o_tlb_invalid),
        .o_tlb_modified (o_tlb_modified),
        .o_probe_wen    (o_probe_wen),
        .o_probe_result (o_probe_result),
        .o_read_wen     (o_read_wen),
        .o_read_entry   (o_read_entry)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic wait_expired(string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        abort_run();
    endtask

    task automatic check_entry(string name, tlb_entry_t got, tlb_entry_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_probe(string name, probe_t got, probe_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, logic [`ADDR_W-1:0] got, logic [`ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Highest hitting index wins, miss reports index 0
    function automatic probe_t model_lookup(entry_hi_t key);
        probe_t res;
        res.miss = 1'b1;
        res.idx  = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (model[i].key.vpn2 == key.vpn2 &&
                (model[i].glb || model[i].key.asid == key.asid)) begin
                res.miss = 1'b0;
                res.idx  = tlb_idx_t'(i);
            end
        end
        return res;
    endfunction

    task automatic make_lo(output entry_lo_t lo);
        logic [31:0] r;
        r = $random(seed);
        lo.pfn   = r[19:0];
        lo.cattr = r[20] ? `CATTR_W'(`CATTR_CACHED) : r[23:21];
        lo.dirty = r[24];
        lo.valid = r[25] | r[26]; // Mostly valid
        lo.glb   = r[27];
    endtask

    task automatic do_write(logic rand_sel);
        logic [31:0] r;
        entry_hi_t   hi;
        entry_lo_t   l0;
        entry_lo_t   l1;
        tlb_idx_t    idx;
        r = $random(seed);
        hi.vpn2 = vpn2_pool[r[2:0]];
        hi.asid = asid_pool[r[4:3]];
        make_lo(l0);
        make_lo(l1);
        i_tlb_op    = rand_sel ? op_write_rand : op_write_idx;
        i_index     = r[8:5];
        i_random    = r[12:9];
        i_entry_hi  = hi;
        i_entry_lo0 = l0;
        i_entry_lo1 = l1;
        idx = rand_sel ? r[12:9] : r[8:5];
        @(negedge clk);
        i_tlb_op = op_nop;
        model[idx].key = hi;
        model[idx].glb = l0.glb & l1.glb;
        model[idx].lo0 = {l0.pfn, l0.cattr, l0.dirty, l0.valid};
        model[idx].lo1 = {l1.pfn, l1.cattr, l1.dirty, l1.valid};
    endtask

    task automatic do_read(tlb_idx_t idx);
        int cnt;
        i_tlb_op = op_read;
        i_index  = idx;
        @(negedge clk);
        i_tlb_op = op_nop;
        cnt = 0;
        while (!o_read_wen) begin
            if (cnt == WAIT_LIMIT) wait_expired("read strobe");
            @(negedge clk);
            cnt++;
        end
        check_count("read strobe latency", cnt, 0);
        check_flag("o_probe_wen", o_probe_wen, 1'b0);
        check_entry("o_read_entry", o_read_entry, model[idx]);
        @(negedge clk);
        check_flag("o_read_wen", o_read_wen, 1'b0); // One-cycle pulse
    endtask

    task automatic do_probe();
        logic [31:0] r;
        entry_hi_t   key;
        int          cnt;
        r = $random(seed);
        key.vpn2   = vpn2_pool[r[2:0]];
        key.asid   = asid_pool[r[4:3]];
        i_entry_hi = key;
        i_tlb_op   = op_probe;
        @(negedge clk);
        i_tlb_op = op_nop;
        cnt = 0;
        while (!o_probe_wen) begin
            if (cnt == WAIT_LIMIT) wait_expired("probe strobe");
            @(negedge clk);
            cnt++;
        end
        check_count("probe strobe latency", cnt, 0);
        check_flag("o_read_wen", o_read_wen, 1'b0);
        check_probe("o_probe_result", o_probe_result, model_lookup(key));
        @(negedge clk);
        check_flag("o_probe_wen", o_probe_wen, 1'b0);
    endtask

    task automatic do_translate(logic [`ADDR_W-1:0] va, logic [`ASID_W-1:0] asid, logic store);
        logic      from_lk;
        entry_hi_t key;
        probe_t    hit;
        tlb_page_t pg;
        int        cnt;
        from_lk = lk_valid && (va == lk_vaddr) && (asid == lk_asid);
        i_dmmu_en       = 1'b1;
        i_dmmu_vaddr    = va;
        i_dmmu_store    = store;
        i_entry_hi.asid = asid;
        #1;
        check_flag("o_dmmu_rdy", o_dmmu_rdy, from_lk); // Lookaside answers at once
        if (!from_lk) begin
            key.vpn2 = va[`ADDR_W-1 -: `VPN2_W];
            key.asid = asid;
            hit = model_lookup(key);
            pg  = va[`PAGE_OFS_W] ? model[hit.idx].lo1 : model[hit.idx].lo0;
            lk_valid    = 1'b1;
            lk_vaddr    = va;
            lk_asid     = asid;
            lk_refill   = hit.miss;
            lk_paddr    = hit.miss ? '0 : {pg.pfn, va[`PAGE_OFS_W-1:0]};
            lk_cached   = !hit.miss && (pg.cattr == `CATTR_W'(`CATTR_CACHED));
            lk_invalid  = !hit.miss && !pg.valid;
            lk_modified = !hit.miss && pg.valid && !pg.dirty && store;
            cnt = 0;
            while (!o_dmmu_rdy) begin
                if (cnt == WAIT_LIMIT) wait_expired("translation ready");
                @(negedge clk);
                cnt++;
            end
            check_count("ready latency", cnt, 3);
        end
        check_addr("o_dmmu_paddr", o_dmmu_paddr, lk_paddr);
        check_flag("o_dmmu_cached", o_dmmu_cached, lk_cached);
        check_flag("o_tlb_refill", o_tlb_refill, lk_refill);
        check_flag("o_tlb_invalid", o_tlb_invalid, lk_invalid);
        check_flag("o_tlb_modified", o_tlb_modified, lk_modified);
        i_dmmu_en = 1'b0;
    endtask

    initial begin
        logic [31:0]        r;
        logic [`ADDR_W-1:0] va;
        seed         = 70;
        rst          = 1'b1;
        i_tlb_op     = op_nop;
        i_index      = '0;
        i_random     = '0;
        i_entry_hi   = '0;
        i_entry_lo0  = '0;
        i_entry_lo1  = '0;
        i_dmmu_en    = 1'b0;
        i_dmmu_vaddr = '0;
        i_dmmu_store = 1'b0;
        lk_valid     = 1'b0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            model[i] = '0;
        end
        // Small pools so keys collide often
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            vpn2_pool[i] = {r[15:0], i[2:0]};
        end
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            asid_pool[i] = {r[5:0], i[1:0]};
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_flag("o_dmmu_rdy", o_dmmu_rdy, 1'b0);
        check_flag("o_read_wen", o_read_wen, 1'b0);
        check_flag("o_probe_wen", o_probe_wen, 1'b0);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            do_read(tlb_idx_t'(i));
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0:    do_write(1'b0);
                3'd1:    do_write(1'b1);
                3'd2:    do_read(r[11:8]);
                3'd3:    do_probe();
                default: begin
                    if (lk_valid && r[5:4] == 2'd0) begin
                        do_translate(lk_vaddr, lk_asid, r[6]);
                    end else if (lk_valid && r[5:4] == 2'd1) begin
                        do_translate(lk_vaddr, asid_pool[r[13:12]], r[6]);
                    end else begin
                        va = {vpn2_pool[r[18:16]], r[7], r[31:20]};
                        do_translate(va, asid_pool[r[13:12]], r[6]);
                    end
                end
            endcase
        end

        // Lookaside hit, then asid change forces a new walk
        do_translate({vpn2_pool[0], 13'h1abc}, asid_pool[1], 1'b0);
        do_translate({vpn2_pool[0], 13'h1abc}, asid_pool[1], 1'b1);
        do_translate({vpn2_pool[0], 13'h1abc}, asid_pool[2], 1'b1);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
source/tlb_pkg.sv
source/tlb_entry_array.sv
source/tlb_match.sv
source/tlb_translate_ctrl.sv
source/tlb_unit.sv
verification/tlb_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the TLB testbench with Verilator and run it.
# The exit status is the simulator's status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f all.f \
    --top-module tlb_unit_tb \
    -o tlb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tlb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0
